// File: hdl/rv32_pred_pkg.sv
package rv32_pred_pkg;

	// rv32i major opcodes seen by the predictor
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	// link registers for the return address hints
	localparam logic [4:0] REG_RA = 5'd1;
	localparam logic [4:0] REG_T0 = 5'd5;

	// return address stack sizing
	localparam int RAS_DEPTH = 4;
	localparam int RAS_PTR_W = $clog2(RAS_DEPTH);
	// count runs 0..RAS_DEPTH so it needs one more bit than the pointer
	localparam int RAS_CNT_W = RAS_PTR_W + 1;
	localparam logic [RAS_CNT_W-1:0] RAS_FULL = RAS_CNT_W'(RAS_DEPTH);

	// branch history table sizing
	localparam int BHT_ENTRIES = 16;
	localparam int BHT_IDX_W   = $clog2(BHT_ENTRIES);

	// 2-bit counter values
	localparam logic [1:0] CNT_INIT = 2'b01;
	localparam logic [1:0] CNT_MAX  = 2'b11;

	typedef enum logic [1:0] {
		CLS_OTHER,
		CLS_BRANCH,
		CLS_JAL,
		CLS_JALR
	} inst_class_t;

	typedef enum logic [1:0] {
		RAS_NONE,
		RAS_PUSH,
		RAS_POP,
		RAS_POP_PUSH
	} ras_op_t;

	// one fetched word
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_t;

	// branch outcome from execute
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        taken;
	} resolve_t;

	// registered prediction towards fetch
	typedef struct packed {
		logic        valid;
		logic        taken;
		logic [31:0] next_pc;
		logic        from_ras;
	} pred_t;

	// predecode result for the word in the stage register
	typedef struct packed {
		inst_class_t cls;
		ras_op_t     ras_op;
		logic [31:0] target;
		logic [31:0] link_pc;
	} decode_t;

endpackage

// File: hdl/predecode.sv
`timescale 1ns/1ps

module predecode (
	input  rv32_pred_pkg::fetch_t  stage,
	output rv32_pred_pkg::decode_t dec
);

	logic [6:0]  opcode;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic        rd_link;
	logic        rs1_link;
	logic [31:0] imm_b;
	logic [31:0] imm_j;

	assign opcode = stage.instr[6:0];
	assign rd     = stage.instr[11:7];
	assign rs1    = stage.instr[19:15];

	// x1 and x5 are the only registers treated as link registers
	assign rd_link  = (rd == rv32_pred_pkg::REG_RA) || (rd == rv32_pred_pkg::REG_T0);
	assign rs1_link = (rs1 == rv32_pred_pkg::REG_RA) || (rs1 == rv32_pred_pkg::REG_T0);

	// b-type immediate, bit 0 always zero
	assign imm_b = {{20{stage.instr[31]}}, stage.instr[7], stage.instr[30:25],
		stage.instr[11:8], 1'b0};

	// j-type immediate
	assign imm_j = {{12{stage.instr[31]}}, stage.instr[19:12], stage.instr[20],
		stage.instr[30:21], 1'b0};

	always_comb begin
		dec.cls     = rv32_pred_pkg::CLS_OTHER;
		dec.ras_op  = rv32_pred_pkg::RAS_NONE;
		dec.link_pc = stage.pc + 32'd4;
		// branch target by default, jal overrides
		dec.target  = stage.pc + imm_b;

		case (opcode)
		rv32_pred_pkg::OP_BRANCH: begin
			dec.cls = rv32_pred_pkg::CLS_BRANCH;
		end
		rv32_pred_pkg::OP_JAL: begin
			dec.cls    = rv32_pred_pkg::CLS_JAL;
			dec.target = stage.pc + imm_j;
			// call when linking
			if (rd_link) begin
				dec.ras_op = rv32_pred_pkg::RAS_PUSH;
			end
		end
		rv32_pred_pkg::OP_JALR: begin
			dec.cls = rv32_pred_pkg::CLS_JALR;
			case ({rd_link, rs1_link})
			2'b01: dec.ras_op = rv32_pred_pkg::RAS_POP;
			2'b10: dec.ras_op = rv32_pred_pkg::RAS_PUSH;
			2'b11: begin
				// same link register means a plain call
				if (rd == rs1) begin
					dec.ras_op = rv32_pred_pkg::RAS_PUSH;
				end else begin
					dec.ras_op = rv32_pred_pkg::RAS_POP_PUSH;
				end
			end
			default: dec.ras_op = rv32_pred_pkg::RAS_NONE;
			endcase
		end
		default: begin
			dec.cls = rv32_pred_pkg::CLS_OTHER;
		end
		endcase
	end

endmodule

// File: hdl/return_stack.sv
`timescale 1ns/1ps

module return_stack (
	input  logic                   CLK,
	input  logic                   nRST,
	input  rv32_pred_pkg::ras_op_t op,
	input  logic [31:0]            push_addr,
	output logic [31:0]            top_addr,
	output logic                   nonempty
);

	logic [31:0] entries [rv32_pred_pkg::RAS_DEPTH];

	// ptr is the next free slot, the top lives one below it
	logic [rv32_pred_pkg::RAS_PTR_W-1:0] ptr;
	logic [rv32_pred_pkg::RAS_PTR_W-1:0] ptr_top;
	logic [rv32_pred_pkg::RAS_CNT_W-1:0] count;

	assign ptr_top  = ptr - 1'b1;
	assign top_addr = entries[ptr_top];
	assign nonempty = (count != '0);

	// storage
	always_ff @(posedge CLK) begin
		case (op)
		rv32_pred_pkg::RAS_PUSH: begin
			// a full stack simply overwrites its oldest slot here
			entries[ptr] <= push_addr;
		end
		rv32_pred_pkg::RAS_POP_PUSH: begin
			entries[ptr_top] <= push_addr;
		end
		default: begin
		end
		endcase
	end

	// pointer and occupancy
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ptr   <= '0;
			count <= '0;
		end else begin
			case (op)
			rv32_pred_pkg::RAS_PUSH: begin
				ptr <= ptr + 1'b1;
				if (count != rv32_pred_pkg::RAS_FULL) begin
					count <= count + 1'b1;
				end
			end
			rv32_pred_pkg::RAS_POP: begin
				// popping an empty stack is a no-op
				if (nonempty) begin
					ptr   <= ptr_top;
					count <= count - 1'b1;
				end
			end
			rv32_pred_pkg::RAS_POP_PUSH: begin
				// top replaced in place, empty stack gains its first entry
				if (!nonempty) begin
					count <= {{rv32_pred_pkg::RAS_PTR_W{1'b0}}, 1'b1};
				end
			end
			default: begin
			end
			endcase
		end
	end

	// occupancy stays bounded across any run of pushes
	a_count_bound: assert property (
		@(posedge CLK) disable iff (!nRST)
		count <= rv32_pred_pkg::RAS_FULL
	) else $error("return stack count %0d above depth", count);

	// the op must be clean once the stage register is out of reset
	a_op_known: assert property (
		@(posedge CLK) disable iff (!nRST)
		!$isunknown(op)
	) else $error("return stack op unknown");

endmodule

// File: hdl/branch_history.sv
`timescale 1ns/1ps

module branch_history (
	input  logic                    CLK,
	input  logic                    nRST,
	input  logic [31:0]             rd_pc,
	output logic                    taken_hint,
	input  rv32_pred_pkg::resolve_t resolve
);

	logic [1:0] counters [rv32_pred_pkg::BHT_ENTRIES];

	logic [rv32_pred_pkg::BHT_IDX_W-1:0] rd_idx;
	logic [rv32_pred_pkg::BHT_IDX_W-1:0] wr_idx;

	// word index, pc bits 1:0 are always zero
	assign rd_idx = rd_pc[rv32_pred_pkg::BHT_IDX_W+1:2];
	assign wr_idx = resolve.pc[rv32_pred_pkg::BHT_IDX_W+1:2];

	// msb of the counter is the prediction
	assign taken_hint = counters[rd_idx][1];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < rv32_pred_pkg::BHT_ENTRIES; i++) begin
				counters[i] <= rv32_pred_pkg::CNT_INIT;
			end
		end else if (resolve.valid) begin
			if (resolve.taken) begin
				// saturate at strongly taken
				if (counters[wr_idx] != rv32_pred_pkg::CNT_MAX) begin
					counters[wr_idx] <= counters[wr_idx] + 1'b1;
				end
			end else begin
				// saturate at strongly not taken
				if (counters[wr_idx] != 2'b00) begin
					counters[wr_idx] <= counters[wr_idx] - 1'b1;
				end
			end
		end
	end

	// execute only reports aligned rv32i pcs
	a_resolve_aligned: assert property (
		@(posedge CLK) disable iff (!nRST)
		resolve.valid |-> (resolve.pc[1:0] == 2'b00)
	) else $error("misaligned resolve pc %h", resolve.pc);

endmodule

// File: hdl/next_pc_predictor.sv
`timescale 1ns/1ps

module next_pc_predictor (
	input  logic                    CLK,
	input  logic                    nRST,
	input  rv32_pred_pkg::fetch_t   fetch,
	input  rv32_pred_pkg::resolve_t resolve,
	output rv32_pred_pkg::pred_t    pred
);

	// stage register
	logic        stage_valid;
	logic [31:0] stage_pc;
	logic [31:0] stage_instr;

	rv32_pred_pkg::fetch_t  stage;
	rv32_pred_pkg::decode_t dec;
	rv32_pred_pkg::ras_op_t stack_op;

	logic [31:0] top_addr;
	logic        nonempty;
	logic        taken_hint;

	// next pc selection
	logic [31:0] sel_pc;
	logic        sel_taken;
	logic        sel_ras;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= fetch.valid;
		end
	end

	always_ff @(posedge CLK) begin
		stage_pc    <= fetch.pc;
		stage_instr <= fetch.instr;
	end

	assign stage = '{valid: stage_valid, pc: stage_pc, instr: stage_instr};

	predecode u_predecode (
		.stage (stage),
		.dec   (dec)
	);

	// idle cycles must leave the stack alone
	assign stack_op = stage_valid ? dec.ras_op : rv32_pred_pkg::RAS_NONE;

	return_stack u_return_stack (
		.CLK       (CLK),
		.nRST      (nRST),
		.op        (stack_op),
		.push_addr (dec.link_pc),
		.top_addr  (top_addr),
		.nonempty  (nonempty)
	);

	branch_history u_branch_history (
		.CLK        (CLK),
		.nRST       (nRST),
		.rd_pc      (stage_pc),
		.taken_hint (taken_hint),
		.resolve    (resolve)
	);

	always_comb begin
		sel_pc    = dec.link_pc;
		sel_taken = 1'b0;
		sel_ras   = 1'b0;
		case (dec.cls)
		rv32_pred_pkg::CLS_BRANCH: begin
			if (taken_hint) begin
				sel_pc    = dec.target;
				sel_taken = 1'b1;
			end
		end
		rv32_pred_pkg::CLS_JAL: begin
			sel_pc    = dec.target;
			sel_taken = 1'b1;
		end
		rv32_pred_pkg::CLS_JALR: begin
			// only returns get a target, and only from a live entry
			if ((dec.ras_op == rv32_pred_pkg::RAS_POP ||
				dec.ras_op == rv32_pred_pkg::RAS_POP_PUSH) && nonempty) begin
				sel_pc    = top_addr;
				sel_taken = 1'b1;
				sel_ras   = 1'b1;
			end
		end
		default: begin
		end
		endcase
	end

	// output register
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pred <= '0;
		end else begin
			pred.valid    <= stage_valid;
			pred.taken    <= sel_taken;
			pred.next_pc  <= sel_pc;
			pred.from_ras <= sel_ras;
		end
	end

	// stack targets and immediates together must keep fetch word aligned
	a_pred_aligned: assert property (
		@(posedge CLK) disable iff (!nRST)
		pred.valid |-> (pred.next_pc[1:0] == 2'b00)
	) else $error("misaligned predicted pc %h", pred.next_pc);

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// reset held low over the first three rising edges
	initial begin
		nRST = 1'b0;
		repeat (3) @(posedge CLK);
		#1 nRST = 1'b1;
	end

endmodule

// File: testbench/tb_pred_model.svh
`ifndef TB_PRED_MODEL_SVH
`define TB_PRED_MODEL_SVH

// return addresses, newest at the back
logic [31:0]           ras_model [$];
logic [1:0]            cnt_model [rv32_pred_pkg::BHT_ENTRIES];
// word the DUT holds in its stage register
rv32_pred_pkg::fetch_t stage_model;
// predictions still to come out of the DUT
rv32_pred_pkg::pred_t  expect_q [$];
string                 name_q [$];

task automatic model_reset();
	ras_model.delete();
	foreach (cnt_model[i]) begin
		cnt_model[i] = 2'd1;
	end
	stage_model = '0;
	expect_q.delete();
	name_q.delete();
endtask

function automatic logic is_link(input logic [4:0] r);
	return (r == 5'd1) || (r == 5'd5);
endfunction

task automatic model_predict(
	input  rv32_pred_pkg::fetch_t w,
	output rv32_pred_pkg::pred_t  p,
	output string                 name
);
	logic [31:0]        seq_pc;
	logic signed [12:0] b_imm;
	logic signed [20:0] j_imm;
	logic               pops;
	logic               pushes;
	int                 idx;
	seq_pc     = w.pc + 32'd4;
	b_imm      = {w.instr[31], w.instr[7], w.instr[30:25], w.instr[11:8], 1'b0};
	j_imm      = {w.instr[31], w.instr[19:12], w.instr[20], w.instr[30:21], 1'b0};
	idx        = int'((w.pc >> 2) % rv32_pred_pkg::BHT_ENTRIES);
	pops       = 1'b0;
	pushes     = 1'b0;
	p.valid    = w.valid;
	p.taken    = 1'b0;
	p.next_pc  = seq_pc;
	p.from_ras = 1'b0;
	name       = "other";
	case (w.instr[6:0])
	rv32_pred_pkg::OP_BRANCH: begin
		name = "branch";
		// upper half of the counter range means taken
		if (cnt_model[idx] >= 2'd2) begin
			p.taken   = 1'b1;
			p.next_pc = w.pc + 32'(b_imm);
		end
	end
	rv32_pred_pkg::OP_JAL: begin
		name      = "jal";
		p.taken   = 1'b1;
		p.next_pc = w.pc + 32'(j_imm);
		pushes    = is_link(w.instr[11:7]);
	end
	rv32_pred_pkg::OP_JALR: begin
		name   = "jalr";
		pushes = is_link(w.instr[11:7]);
		pops   = is_link(w.instr[19:15]) && !(pushes && w.instr[11:7] == w.instr[19:15]);
		if (pops && ras_model.size() > 0) begin
			name       = "return";
			p.taken    = 1'b1;
			p.next_pc  = ras_model[$];
			p.from_ras = 1'b1;
		end
	end
	default: begin
	end
	endcase
	// idle cycles leave the stack alone
	if (w.valid) begin
		if (pops && ras_model.size() > 0) begin
			void'(ras_model.pop_back());
		end
		if (pushes) begin
			ras_model.push_back(seq_pc);
			// oldest entry lost once the stack is over depth
			if (ras_model.size() > rv32_pred_pkg::RAS_DEPTH) begin
				void'(ras_model.pop_front());
			end
		end
	end
	name = $sformatf("%s@%h", name, w.pc);
endtask

task automatic model_train(input rv32_pred_pkg::resolve_t r);
	int idx;
	idx = int'((r.pc >> 2) % rv32_pred_pkg::BHT_ENTRIES);
	if (r.valid) begin
		if (r.taken && cnt_model[idx] != 2'd3) begin
			cnt_model[idx] = cnt_model[idx] + 2'd1;
		end else if (!r.taken && cnt_model[idx] != 2'd0) begin
			cnt_model[idx] = cnt_model[idx] - 2'd1;
		end
	end
endtask

// one clock of the predictor, read before the counters train
task automatic model_step();
	rv32_pred_pkg::pred_t p;
	string                name;
	model_predict(stage_model, p, name);
	if (p.valid) begin
		expect_q.push_back(p);
		name_q.push_back(name);
	end
	model_train(resolve);
	stage_model = fetch;
endtask

`endif

// File: testbench/tb_next_pc_predictor.sv
`timescale 1ns/1ps

module tb_next_pc_predictor;

	localparam int          NUM_CYCLES     = 3000;
	localparam int          DRAIN_CYCLES   = 4;
	localparam int          TIMEOUT_CYCLES = NUM_CYCLES + 50;
	localparam logic [31:0] SEED           = 32'hec5c_11c4;
	localparam logic [31:0] PC_BASE        = 32'h0000_1000;
	// register choices for jal and jalr operands
	localparam logic [4:0]  REGS [4]       = '{5'd0, 5'd1, 5'd5, 5'd6};

	logic                    CLK;
	logic                    nRST;
	rv32_pred_pkg::fetch_t   fetch;
	rv32_pred_pkg::resolve_t resolve;
	rv32_pred_pkg::pred_t    pred;

	logic [31:0] lcg_state;
	int          cycle_count    = 0;
	int          stim_count     = 0;
	int          checked_count  = 0;
	int          mismatch_count = 0;
	int          other_count    = 0;

	tb_clock u_clock (
		.CLK  (CLK),
		.nRST (nRST)
	);

	next_pc_predictor dut0 (
		.CLK     (CLK),
		.nRST    (nRST),
		.fetch   (fetch),
		.resolve (resolve),
		.pred    (pred)
	);

	`include "tb_pred_model.svh"

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic make_word(output rv32_pred_pkg::fetch_t f);
		logic [31:0] r;
		logic [31:0] w;
		logic [4:0]  rd;
		r       = next_rand();
		w       = next_rand();
		rd      = REGS[r[22:21]];
		f.valid = 1'b1;
		f.pc    = PC_BASE + {25'd0, r[27:23], 2'b00};
		// bit 8 of a branch and bit 21 of a jal kept clear for aligned targets
		if (r[31:28] <= 4'd2) begin
			f.instr = {w[31:9], 1'b0, w[7], rv32_pred_pkg::OP_BRANCH};
		end else if (r[31:28] <= 4'd4) begin
			f.instr = {w[31:22], 1'b0, w[20:12], (rd == 5'd6) ? 5'd1 : rd,
				rv32_pred_pkg::OP_JAL};
		end else if (r[31:28] <= 4'd8) begin
			f.instr = {w[31:20], REGS[r[20:19]], w[14:12], rd, rv32_pred_pkg::OP_JALR};
		end else if (r[31:28] <= 4'd12) begin
			f.instr = {w[31:7], w[5] ? 7'b0110011 : 7'b0010011};
		end else begin
			f.valid = 1'b0;
			f.instr = w;
		end
	endtask

	task automatic make_resolve(output rv32_pred_pkg::resolve_t res);
		logic [31:0] r;
		r         = next_rand();
		res.valid = r[31] | r[30];
		res.pc    = PC_BASE + {25'd0, r[27:23], 2'b00};
		// odd counters lean taken, even ones not taken
		res.taken = r[23] ? (r[22:20] != 3'd0) : (r[22:20] == 3'd0);
	endtask

	task automatic drive_cycle(input rv32_pred_pkg::fetch_t f, input rv32_pred_pkg::resolve_t res);
		@(posedge CLK);
		#1;
		fetch   = f;
		resolve = res;
		stim_count++;
	endtask

	// five calls overflow the stack, six returns drain it past empty,
	// then a pop-then-push on the empty stack and its return
	task automatic run_calls_and_returns();
		rv32_pred_pkg::fetch_t f;
		f.valid = 1'b1;
		for (int i = 0; i < 11; i++) begin
			f.pc    = (i < 5) ? 32'h0000_2000 + 32'(i) * 32'h100 : 32'h0000_3000 + 32'(i) * 32'h10;
			f.instr = (i < 5) ? 32'h0000_00ef : 32'h0000_8067;
			drive_cycle(f, '0);
		end
		f.pc    = 32'h0000_4000;
		f.instr = 32'h0000_82e7;
		drive_cycle(f, '0);
		f.pc    = 32'h0000_4800;
		f.instr = 32'h0002_8067;
		drive_cycle(f, '0);
	endtask

	task automatic check_pred();
		rv32_pred_pkg::pred_t exp;
		string                name;
		if (pred.valid === 1'b1) begin
			if (expect_q.size() == 0) begin
				other_count++;
				$display("ERROR: valid prediction with no word in flight at cycle %0d",
					cycle_count);
			end else begin
				exp  = expect_q.pop_front();
				name = name_q.pop_front();
				checked_count++;
				if (pred.next_pc !== exp.next_pc || pred.taken !== exp.taken ||
					pred.from_ras !== exp.from_ras) begin
					mismatch_count++;
					$display("Mismatch %s next_pc/taken/from_ras expected %h/%b/%b actual %h/%b/%b",
						name, exp.next_pc, exp.taken, exp.from_ras,
						pred.next_pc, pred.taken, pred.from_ras);
				end
			end
		end else if (pred.valid !== 1'b0) begin
			other_count++;
			$display("ERROR: prediction valid is unknown at cycle %0d", cycle_count);
		end else if (expect_q.size() != 0) begin
			other_count++;
			$display("ERROR: no valid prediction came out for %s", name_q[0]);
			void'(expect_q.pop_front());
			void'(name_q.pop_front());
		end
	endtask

	// outputs and driven inputs are both stable at the falling edge
	always @(negedge CLK) begin
		check_pred();
		if (nRST !== 1'b1) begin
			model_reset();
		end else begin
			model_step();
		end
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("ERROR: timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin : stimulus
		rv32_pred_pkg::fetch_t   f;
		rv32_pred_pkg::resolve_t res;
		int                      end_errors;
		fetch      = '0;
		resolve    = '0;
		lcg_state  = SEED;
		end_errors = 0;
		wait (nRST === 1'b1);
		run_calls_and_returns();
		while (stim_count < NUM_CYCLES) begin
			make_word(f);
			make_resolve(res);
			drive_cycle(f, res);
		end
		repeat (DRAIN_CYCLES) drive_cycle('0, '0);
		@(posedge CLK);
		#2;
		if (checked_count == 0) begin
			end_errors++;
			$display("ERROR: no prediction was checked");
		end
		if (expect_q.size() != 0) begin
			end_errors++;
			$display("ERROR: %0d predictions never came out", expect_q.size());
		end
		$display("checked %0d predictions, %0d mismatches, %0d other errors",
			checked_count, mismatch_count, other_count + end_errors);
		if (mismatch_count == 0 && other_count == 0 && end_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+testbench
hdl/rv32_pred_pkg.sv
hdl/predecode.sv
hdl/return_stack.sv
hdl/branch_history.sv
hdl/next_pc_predictor.sv
testbench/tb_clock.sv
testbench/tb_next_pc_predictor.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_next_pc_predictor
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= === FAIL ===

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
